// ==== flist.f ====
logic/soc_pkg.sv
logic/sram_bank.sv
logic/soc_ctrl_regs.sv
logic/gpio_regs.sv
logic/periph_demux.sv
logic/bus_router.sv
logic/soc_domain.sv
sim/tb_soc_domain.sv

// ==== logic/bus_router.sv ====
`timescale 1ns/1ps

module bus_router import soc_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [AddrWidth-1:0]                 addr_i,
  input  logic [DataWidth-1:0]                 wdata_i,
  input  logic [BeWidth-1:0]                   be_i,
  output logic [NumSramBanks-1:0]              bank_req_o,
  output logic                                 periph_req_o,
  output logic                                 sub_we_o,
  output logic [AddrWidth-1:0]                 sub_addr_o,
  output logic [DataWidth-1:0]                 sub_wdata_o,
  output logic [BeWidth-1:0]                   sub_be_o,
  input  logic [NumSramBanks-1:0][DataWidth-1:0] bank_rdata_i,
  input  logic [DataWidth-1:0]                 periph_rdata_i,
  input  logic                                 periph_err_i,
  output logic                                 rvalid_o,
  output logic [DataWidth-1:0]                 rdata_o,
  output logic                                 err_o
);

  logic [TgtIdxWidth-1:0] tgt_d;
  logic [TgtIdxWidth-1:0] tgt_q;
  logic                   valid_q;
  logic [AddrWidth-1:0]   bank_base;

  // ------------------------------------------------------------------------
  // Address decode with the error target as default
  // ------------------------------------------------------------------------
  always_comb begin
    tgt_d     = TgtIdxWidth'(TgtErr);
    bank_base = SramBaseAddr;
    for (int unsigned i = 0; i < NumSramBanks; i++) begin
      bank_base = SramBaseAddr + AddrWidth'(i) * SramBankBytes;
      if (addr_i >= bank_base && addr_i < bank_base + SramBankBytes) begin
        tgt_d = TgtIdxWidth'(i);
      end
    end
    if (addr_i >= PeriphBaseAddr && addr_i < PeriphBaseAddr + PeriphSize) begin
      tgt_d = TgtIdxWidth'(TgtPeriph);
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NumSramBanks; i++) begin
      bank_req_o[i] = req_i && (tgt_d == TgtIdxWidth'(i));
    end
  end

  assign periph_req_o = req_i && (tgt_d == TgtIdxWidth'(TgtPeriph));
  assign sub_we_o     = we_i;
  assign sub_addr_o   = addr_i;
  assign sub_wdata_o  = wdata_i;
  assign sub_be_o     = be_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      tgt_q   <= '0;
    end else begin
      valid_q <= req_i;
      if (req_i) tgt_q <= tgt_d;
    end
  end

  // ------------------------------------------------------------------------
  // Response path one cycle after the request
  // ------------------------------------------------------------------------
  always_comb begin
    rdata_o = BusErrData;
    err_o   = 1'b1;
    for (int unsigned i = 0; i < NumSramBanks; i++) begin
      if (tgt_q == TgtIdxWidth'(i)) begin
        rdata_o = bank_rdata_i[i];
        err_o   = 1'b0;
      end
    end
    if (tgt_q == TgtIdxWidth'(TgtPeriph)) begin
      rdata_o = periph_rdata_i;
      err_o   = periph_err_i;
    end
  end

  assign rvalid_o = valid_q;

endmodule

// ==== logic/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs import soc_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [BlockOffsetWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [BeWidth-1:0]          be_i,
  input  logic [GpioCount-1:0]        gpio_i,
  output logic [DataWidth-1:0]        rdata_o,
  output logic [GpioCount-1:0]        gpio_o,
  output logic [GpioCount-1:0]        gpio_out_en_o,
  output logic [GpioCount-1:0]        gpio_in_sync_o
);

  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] sync0_q;
  logic [GpioCount-1:0] sync1_q;
  logic [GpioCount-1:0] wmask;
  logic [GpioCount-1:0] wbits;
  logic [DataWidth-1:0] rdata_q;
  logic [BlockOffsetWidth-3:0] word;

  assign word  = addr_i[BlockOffsetWidth-1:2];
  assign wbits = wdata_i[GpioCount-1:0];

  // Expand byte enables to a per-pin mask
  always_comb begin
    for (int unsigned b = 0; b < GpioCount; b++) begin
      wmask[b] = be_i[b/8];
    end
  end

  // ------------------------------------------------------------------------
  // Direction and output registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (req_i && we_i) begin
      if (word == RegGpioDir[BlockOffsetWidth-1:2]) dir_q <= (dir_q & ~wmask) | (wbits & wmask);
      if (word == RegGpioOut[BlockOffsetWidth-1:2]) out_q <= (out_q & ~wmask) | (wbits & wmask);
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync0_q <= '0;
      sync1_q <= '0;
    end else begin
      sync0_q <= gpio_i;
      sync1_q <= sync0_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= '0;
      if (word == RegGpioDir[BlockOffsetWidth-1:2]) rdata_q <= DataWidth'(dir_q);
      if (word == RegGpioOut[BlockOffsetWidth-1:2]) rdata_q <= DataWidth'(out_q);
      if (word == RegGpioIn[BlockOffsetWidth-1:2])  rdata_q <= DataWidth'(sync1_q);
    end
  end

  assign rdata_o        = rdata_q;
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync1_q;

endmodule

// ==== logic/periph_demux.sv ====
`timescale 1ns/1ps

module periph_demux import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic                 fetch_en_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,
  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 fetch_enable_o,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o
);

  logic                 sel_ctrl;
  logic                 sel_gpio;
  logic                 sel_ctrl_q;
  logic                 sel_gpio_q;
  logic [DataWidth-1:0] ctrl_rdata;
  logic [DataWidth-1:0] gpio_rdata;

  // Block select from the upper offset bits
  assign sel_ctrl = (addr_i[PeriphOffsetWidth-1:BlockOffsetWidth] ==
                     SocCtrlOffset[PeriphOffsetWidth-1:BlockOffsetWidth]);
  assign sel_gpio = (addr_i[PeriphOffsetWidth-1:BlockOffsetWidth] ==
                     GpioOffset[PeriphOffsetWidth-1:BlockOffsetWidth]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_ctrl_q <= 1'b0;
      sel_gpio_q <= 1'b0;
    end else if (req_i) begin
      sel_ctrl_q <= sel_ctrl;
      sel_gpio_q <= sel_gpio;
    end
  end

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .req_i          ( req_i && sel_ctrl              ),
    .we_i,
    .addr_i         ( addr_i[BlockOffsetWidth-1:0]   ),
    .wdata_i,
    .be_i,
    .fetch_en_i,
    .rdata_o        ( ctrl_rdata                     ),
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs i_gpio (
    .clk_i,
    .arst_n_i,
    .req_i          ( req_i && sel_gpio              ),
    .we_i,
    .addr_i         ( addr_i[BlockOffsetWidth-1:0]   ),
    .wdata_i,
    .be_i,
    .gpio_i,
    .rdata_o        ( gpio_rdata                     ),
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o
  );

  // Neither block selected means a miss
  assign rdata_o = sel_ctrl_q ? ctrl_rdata : (sel_gpio_q ? gpio_rdata : BusErrData);
  assign err_o   = !sel_ctrl_q && !sel_gpio_q;

endmodule

// ==== logic/soc_ctrl_regs.sv ====
`timescale 1ns/1ps

module soc_ctrl_regs import soc_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [BlockOffsetWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [BeWidth-1:0]          be_i,
  input  logic                        fetch_en_i,
  output logic [DataWidth-1:0]        rdata_o,
  output logic [AddrWidth-1:0]        boot_addr_o,
  output logic                        fetch_enable_o
);

  logic [AddrWidth-1:0] boot_addr_q;
  logic                 fetch_en_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 hit_boot;
  logic                 hit_fetch;

  assign hit_boot  = (addr_i[BlockOffsetWidth-1:2] == RegBootAddr[BlockOffsetWidth-1:2]);
  assign hit_fetch = (addr_i[BlockOffsetWidth-1:2] == RegFetchEn[BlockOffsetWidth-1:2]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
    end else if (req_i && we_i) begin
      if (hit_boot) begin
        for (int unsigned i = 0; i < BeWidth; i++) begin
          if (be_i[i]) begin
            boot_addr_q[8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      if (hit_fetch && be_i[0]) begin
        fetch_en_q <= wdata_i[0];
      end
    end
  end

  // Unmapped offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= '0;
      if (hit_boot)  rdata_q <= boot_addr_q;
      if (hit_fetch) rdata_q <= DataWidth'(fetch_en_q);
    end
  end

  assign rdata_o        = rdata_q;
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// ==== logic/soc_domain.sv ====
`timescale 1ns/1ps

module soc_domain import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 fetch_en_i,

  // Manager port
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]   be_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,

  // GPIO pins where out_en 1 means output
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,

  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 fetch_enable_o
);

  logic [NumSramBanks-1:0]                 bank_req;
  logic [NumSramBanks-1:0][DataWidth-1:0]  bank_rdata;
  logic                                    periph_req;
  logic [DataWidth-1:0]                    periph_rdata;
  logic                                    periph_err;
  logic                                    sub_we;
  logic [AddrWidth-1:0]                    sub_addr;
  logic [DataWidth-1:0]                    sub_wdata;
  logic [BeWidth-1:0]                      sub_be;

  // ------------------------------------------------------------------------
  // Main decode
  // ------------------------------------------------------------------------
  bus_router i_router (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .bank_req_o     ( bank_req     ),
    .periph_req_o   ( periph_req   ),
    .sub_we_o       ( sub_we       ),
    .sub_addr_o     ( sub_addr     ),
    .sub_wdata_o    ( sub_wdata    ),
    .sub_be_o       ( sub_be       ),
    .bank_rdata_i   ( bank_rdata   ),
    .periph_rdata_i ( periph_rdata ),
    .periph_err_i   ( periph_err   ),
    .rvalid_o,
    .rdata_o,
    .err_o
  );

  // ------------------------------------------------------------------------
  // Memories
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumSramBanks; i++) begin : gen_sram_bank
    // Word index within the bank
    sram_bank i_sram (
      .clk_i,
      .req_i   ( bank_req[i]                        ),
      .we_i    ( sub_we                             ),
      .addr_i  ( sub_addr[SramBankAddrWidth+1:2]    ),
      .wdata_i ( sub_wdata                          ),
      .be_i    ( sub_be                             ),
      .rdata_o ( bank_rdata[i]                      )
    );
  end

  // ------------------------------------------------------------------------
  // Peripherals
  // ------------------------------------------------------------------------
  periph_demux i_periph (
    .clk_i,
    .arst_n_i,
    .req_i          ( periph_req   ),
    .we_i           ( sub_we       ),
    .addr_i         ( sub_addr     ),
    .wdata_i        ( sub_wdata    ),
    .be_i           ( sub_be       ),
    .fetch_en_i,
    .gpio_i,
    .rdata_o        ( periph_rdata ),
    .err_o          ( periph_err   ),
    .boot_addr_o,
    .fetch_enable_o,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o
  );

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ------------------------------------------------------------------------
  // Memory map
  // ------------------------------------------------------------------------
  localparam int unsigned NumSramBanks      = 2;
  localparam int unsigned SramBankNumWords  = 256;
  localparam int unsigned SramBankAddrWidth = $clog2(SramBankNumWords);
  localparam logic [AddrWidth-1:0] SramBankBytes  = AddrWidth'(SramBankNumWords * BeWidth);
  localparam logic [AddrWidth-1:0] SramBaseAddr   = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] PeriphBaseAddr = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] PeriphSize     = 32'h0001_0000;

  // Peripheral region with 4 KiB blocks
  localparam int unsigned PeriphOffsetWidth = 16;
  localparam int unsigned BlockOffsetWidth  = 12;
  localparam logic [PeriphOffsetWidth-1:0] SocCtrlOffset = 16'h0000;
  localparam logic [PeriphOffsetWidth-1:0] GpioOffset    = 16'h1000;

  // Register word offsets inside a block
  localparam logic [BlockOffsetWidth-1:0] RegBootAddr = 12'h000;
  localparam logic [BlockOffsetWidth-1:0] RegFetchEn  = 12'h004;
  localparam logic [BlockOffsetWidth-1:0] RegGpioDir  = 12'h000;
  localparam logic [BlockOffsetWidth-1:0] RegGpioOut  = 12'h004;
  localparam logic [BlockOffsetWidth-1:0] RegGpioIn   = 12'h008;

  localparam int unsigned GpioCount = 16;

  // Read pattern on any decode miss
  localparam logic [DataWidth-1:0] BusErrData = 32'hBADC_AB1E;

  // Router target codes in bank, peripheral and error order
  localparam int unsigned TgtIdxWidth = $clog2(NumSramBanks + 2);
  localparam int unsigned TgtPeriph   = NumSramBanks;
  localparam int unsigned TgtErr      = NumSramBanks + 1;

endpackage

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank import soc_pkg::*; (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [SramBankAddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  input  logic [BeWidth-1:0]           be_i,
  output logic [DataWidth-1:0]         rdata_o
);

  logic [DataWidth-1:0] mem_q [SramBankNumWords];
  logic [DataWidth-1:0] rdata_q;

  // Byte-wise write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned i = 0; i < BeWidth; i++) begin
        if (be_i[i]) begin
          mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the soc_domain testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --top-module tb_soc_domain -f flist.f -o tb_soc_domain \
  && ./obj_dir/tb_soc_domain 2>&1 | tee sim.log

grep -q "^Result: PASSED$" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_soc_domain.sv ====
`timescale 1ns/1ps

module tb_soc_domain import soc_pkg::*; ();

  localparam int OpIdle      = 0;
  localparam int OpRead      = 1;
  localparam int OpWrite     = 2;
  localparam int MaxEntries  = 128;
  localparam int ShadowWords = NumSramBanks * SramBankNumWords;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 fetch_en_i;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [DataWidth-1:0] wdata_i;
  logic [BeWidth-1:0]   be_i;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 err_o;
  logic [GpioCount-1:0] gpio_i;
  logic [GpioCount-1:0] gpio_o;
  logic [GpioCount-1:0] gpio_out_en_o;
  logic [GpioCount-1:0] gpio_in_sync_o;
  logic [AddrWidth-1:0] boot_addr_o;
  logic                 fetch_enable_o;

  // Stimulus table with expected response
  int                   tab_op    [MaxEntries];
  logic [AddrWidth-1:0] tab_addr  [MaxEntries];
  logic [DataWidth-1:0] tab_wdata [MaxEntries];
  logic [BeWidth-1:0]   tab_be    [MaxEntries];
  logic [DataWidth-1:0] tab_rdata [MaxEntries];
  logic                 tab_err   [MaxEntries];
  logic                 tab_chk   [MaxEntries];
  logic [GpioCount-1:0] tab_gpio  [MaxEntries];
  logic                 tab_fen   [MaxEntries];
  // Register state expected after each entry
  logic [AddrWidth-1:0] st_boot   [MaxEntries];
  logic                 st_fetch  [MaxEntries];
  logic [GpioCount-1:0] st_dir    [MaxEntries];
  logic [GpioCount-1:0] st_out    [MaxEntries];
  int                   n_entries;

  // Reference model state
  logic [DataWidth-1:0] shadow [ShadowWords];
  logic [AddrWidth-1:0] m_boot;
  logic                 m_fetch;
  logic [GpioCount-1:0] m_dir;
  logic [GpioCount-1:0] m_out;
  logic [GpioCount-1:0] cur_gpio;
  logic                 cur_fen;

  int   errors;
  int   checks;
  int   cycles;
  int   cycle_limit;
  int   due_idx;
  int   drive_idx;
  logic started;
  logic done;

  soc_domain dut0 (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_w,
                                                       input logic [DataWidth-1:0] new_w,
                                                       input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic compare_value(input string name, input logic [DataWidth-1:0] exp_v,
                               input logic [DataWidth-1:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  // --------------------------------------------------------------------------
  // Table construction with the reference model
  // --------------------------------------------------------------------------
  task automatic add_entry(input int op, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, input logic [BeWidth-1:0] be);
    int                   k;
    int                   idx;
    logic                 wr;
    logic                 err;
    logic [DataWidth-1:0] rd;
    logic [DataWidth-1:0] tmp;
    logic [15:0]          off;
    logic [9:0]           word;
    k    = n_entries;
    wr   = (op == OpWrite);
    err  = 1'b0;
    rd   = '0;
    off  = addr[15:0];
    word = off[11:2];
    if (op == OpIdle) begin
      rd = '0;
    end else if (addr >= SramBaseAddr && addr < SramBaseAddr + 32'h800) begin
      idx = int'((addr - SramBaseAddr) >> 2);
      if (wr) shadow[idx] = merge_bytes(shadow[idx], wdata, be);
      rd = shadow[idx];
    end else if (addr >= PeriphBaseAddr && addr < PeriphBaseAddr + 32'h1_0000 &&
                 off[15:12] == 4'h0) begin
      if (word == RegBootAddr[11:2]) begin
        if (wr) m_boot = merge_bytes(m_boot, wdata, be);
        rd = m_boot;
      end else if (word == RegFetchEn[11:2]) begin
        if (wr && be[0]) m_fetch = wdata[0];
        rd = DataWidth'(m_fetch);
      end
    end else if (addr >= PeriphBaseAddr && addr < PeriphBaseAddr + 32'h1_0000 &&
                 off[15:12] == 4'h1) begin
      if (word == RegGpioDir[11:2]) begin
        tmp = merge_bytes(DataWidth'(m_dir), wdata, be);
        if (wr) m_dir = tmp[GpioCount-1:0];
        rd = DataWidth'(m_dir);
      end else if (word == RegGpioOut[11:2]) begin
        tmp = merge_bytes(DataWidth'(m_out), wdata, be);
        if (wr) m_out = tmp[GpioCount-1:0];
        rd = DataWidth'(m_out);
      end else if (word == RegGpioIn[11:2]) begin
        // Pin value from two cycles before the read
        rd = (k >= 2) ? DataWidth'(tab_gpio[k-2]) : '0;
      end
    end else begin
      rd  = BusErrData;
      err = 1'b1;
    end
    tab_op[k]    = op;
    tab_addr[k]  = addr;
    tab_wdata[k] = wdata;
    tab_be[k]    = be;
    tab_rdata[k] = rd;
    tab_err[k]   = err;
    tab_chk[k]   = (op == OpRead);
    tab_gpio[k]  = cur_gpio;
    tab_fen[k]   = cur_fen;
    st_boot[k]   = m_boot;
    st_fetch[k]  = m_fetch;
    st_dir[k]    = m_dir;
    st_out[k]    = m_out;
    n_entries    = k + 1;
  endtask

  task automatic build_table();
    logic [AddrWidth-1:0] b1;
    logic [AddrWidth-1:0] boot_a;
    logic [AddrWidth-1:0] fen_a;
    logic [AddrWidth-1:0] gpio_b;
    b1     = SramBaseAddr + 32'h400;
    boot_a = PeriphBaseAddr + AddrWidth'(SocCtrlOffset) + AddrWidth'(RegBootAddr);
    fen_a  = PeriphBaseAddr + AddrWidth'(SocCtrlOffset) + AddrWidth'(RegFetchEn);
    gpio_b = PeriphBaseAddr + AddrWidth'(GpioOffset);
    // SRAM full words and partial updates before the read back
    for (int i = 0; i < 4; i++) begin
      add_entry(OpWrite, SramBaseAddr + 32'(4 * i), $urandom, 4'hf);
      add_entry(OpWrite, b1 + 32'(4 * i), $urandom, 4'hf);
    end
    add_entry(OpWrite, b1 + 32'h3fc, $urandom, 4'hf);
    add_entry(OpWrite, SramBaseAddr + 32'h4, $urandom, 4'b0101);
    add_entry(OpWrite, b1 + 32'h8, $urandom, 4'b1000);
    add_entry(OpWrite, SramBaseAddr + 32'hc, $urandom, 4'b0011);
    for (int i = 0; i < 4; i++) begin
      add_entry(OpRead, SramBaseAddr + 32'(4 * i), '0, 4'hf);
      add_entry(OpRead, b1 + 32'(4 * i), '0, 4'hf);
    end
    add_entry(OpRead, b1 + 32'h3fc, '0, 4'hf);
    // Main map and peripheral region misses
    add_entry(OpWrite, 32'h2000_0000, $urandom, 4'hf);
    add_entry(OpRead, 32'h2000_0000, '0, 4'hf);
    add_entry(OpWrite, SramBaseAddr + 32'h800, $urandom, 4'hf);
    add_entry(OpWrite, PeriphBaseAddr + 32'h8000, $urandom, 4'hf);
    add_entry(OpRead, PeriphBaseAddr + 32'h8000, '0, 4'hf);
    add_entry(OpRead, PeriphBaseAddr + 32'h1_0000, '0, 4'hf);
    add_entry(OpRead, SramBaseAddr, '0, 4'hf);
    add_entry(OpRead, b1, '0, 4'hf);
    // Control block
    add_entry(OpRead, boot_a, '0, 4'hf);
    add_entry(OpWrite, boot_a, 32'h1000_0400, 4'hf);
    add_entry(OpRead, boot_a, '0, 4'hf);
    add_entry(OpWrite, boot_a, 32'hffff_ff80, 4'b0001);
    add_entry(OpRead, boot_a, '0, 4'hf);
    add_entry(OpRead, boot_a + 32'h20, '0, 4'hf);
    // Pin value pairs with the previous entry's register bit
    cur_fen = 1'b1;
    add_entry(OpRead, fen_a, '0, 4'hf);
    cur_fen = 1'b0;
    add_entry(OpWrite, fen_a, 32'h1, 4'hf);
    add_entry(OpRead, fen_a, '0, 4'hf);
    cur_fen = 1'b1;
    add_entry(OpWrite, fen_a, 32'h0, 4'hf);
    add_entry(OpRead, fen_a, '0, 4'hf);
    cur_fen = 1'b0;
    add_entry(OpIdle, '0, '0, '0);
    // GPIO
    add_entry(OpWrite, gpio_b + AddrWidth'(RegGpioDir), 32'h0000_a5c3, 4'hf);
    add_entry(OpWrite, gpio_b + AddrWidth'(RegGpioOut), 32'hffff_5a3c, 4'b0011);
    add_entry(OpWrite, gpio_b + AddrWidth'(RegGpioOut), 32'h0000_00ff, 4'b0001);
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioDir), '0, 4'hf);
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioOut), '0, 4'hf);
    add_entry(OpWrite, gpio_b + AddrWidth'(RegGpioIn), 32'hffff_ffff, 4'hf);
    cur_gpio = 16'h3c96;
    add_entry(OpIdle, '0, '0, '0);
    add_entry(OpIdle, '0, '0, '0);
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioIn), '0, 4'hf);
    cur_gpio = 16'h8001;
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioIn), '0, 4'hf);
    add_entry(OpIdle, '0, '0, '0);
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioIn), '0, 4'hf);
    add_entry(OpRead, gpio_b + 32'h10, '0, 4'hf);
    // Back to back across bank, control and miss
    add_entry(OpRead, SramBaseAddr + 32'h4, '0, 4'hf);
    add_entry(OpRead, boot_a, '0, 4'hf);
    add_entry(OpRead, 32'h2000_0004, '0, 4'hf);
    add_entry(OpWrite, b1 + 32'h4, $urandom, 4'b0110);
    add_entry(OpRead, fen_a, '0, 4'hf);
    add_entry(OpRead, PeriphBaseAddr + 32'h2000, '0, 4'hf);
    add_entry(OpRead, b1 + 32'h4, '0, 4'hf);
    add_entry(OpWrite, 32'h2000_0004, $urandom, 4'hf);
    add_entry(OpRead, gpio_b + AddrWidth'(RegGpioDir), '0, 4'hf);
    add_entry(OpIdle, '0, '0, '0);
  endtask

  // --------------------------------------------------------------------------
  // Drive and check
  // --------------------------------------------------------------------------
  task automatic drive_entry(input int k);
    req_i      = (tab_op[k] != OpIdle);
    we_i       = (tab_op[k] == OpWrite);
    addr_i     = tab_addr[k];
    wdata_i    = tab_wdata[k];
    be_i       = tab_be[k];
    gpio_i     = tab_gpio[k];
    fetch_en_i = tab_fen[k];
    drive_idx  = k;
  endtask

  task automatic check_response(input int k);
    logic [GpioCount-1:0] sync_exp;
    sync_exp = (k >= 1) ? tab_gpio[k-1] : '0;
    checks++;
    if (tab_op[k] == OpIdle) begin
      if (rvalid_o !== 1'b0) begin
        errors++;
        $display("Unexpected rvalid_o at %0t after idle entry %0d", $time, k);
      end
    end else if (rvalid_o !== 1'b1) begin
      errors++;
      $display("Missing rvalid_o at %0t for entry %0d", $time, k);
    end else begin
      compare_value("err_o", DataWidth'(tab_err[k]), DataWidth'(err_o));
      if (tab_chk[k]) compare_value("rdata_o", tab_rdata[k], rdata_o);
    end
    compare_value("boot_addr_o", st_boot[k], boot_addr_o);
    compare_value("fetch_enable_o", DataWidth'(st_fetch[k] | fetch_en_i),
                  DataWidth'(fetch_enable_o));
    compare_value("gpio_out_en_o", DataWidth'(st_dir[k]), DataWidth'(gpio_out_en_o));
    compare_value("gpio_o", DataWidth'(st_out[k]), DataWidth'(gpio_o));
    compare_value("gpio_in_sync_o", DataWidth'(sync_exp), DataWidth'(gpio_in_sync_o));
  endtask

  // Response of an entry is checked one edge after it is due
  always @(posedge clk_i) begin
    if (started) begin
      if (due_idx >= 0) begin
        check_response(due_idx);
        if (due_idx == n_entries - 1) done = 1'b1;
      end else if (rvalid_o !== 1'b0) begin
        errors++;
        $display("Unexpected rvalid_o at %0t with no request pending", $time);
      end
      due_idx = drive_idx;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycles);
      $display("Checked %0d entries, %0d errors", checks, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    fetch_en_i = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    be_i       = '0;
    gpio_i     = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    due_idx    = -1;
    drive_idx  = -1;
    started    = 1'b0;
    done       = 1'b0;
    n_entries  = 0;
    m_boot     = SramBaseAddr;
    m_fetch    = 1'b0;
    m_dir      = '0;
    m_out      = '0;
    cur_gpio   = '0;
    cur_fen    = 1'b0;
    void'($urandom(32'hc4b9_ada2));
    build_table();
    cycle_limit = n_entries * 4 + 100;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // Reset state
    compare_value("boot_addr_o", SramBaseAddr, boot_addr_o);
    compare_value("fetch_enable_o", DataWidth'(fetch_en_i), DataWidth'(fetch_enable_o));
    compare_value("gpio_o", '0, DataWidth'(gpio_o));
    compare_value("gpio_out_en_o", '0, DataWidth'(gpio_out_en_o));
    compare_value("rvalid_o", '0, DataWidth'(rvalid_o));
    started = 1'b1;
    for (int k = 0; k < n_entries; k++) begin
      @(negedge clk_i);
      drive_entry(k);
    end
    @(negedge clk_i);
    req_i     = 1'b0;
    we_i      = 1'b0;
    drive_idx = -1;
    wait (done);
    $display("Checked %0d entries, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
